//--- src/tcb_config.svh
`ifndef TCB_CONFIG_SVH
`define TCB_CONFIG_SVH

// bus geometry
// bytes per bus word, a power of two
`define TCB_BYTES 4

// byte address width
`define TCB_ADR_WIDTH 12

// memory sizing
// number of words in the array
`define TCB_MEM_DEPTH 256

// access timing
// wait states between accept and access, zero allowed
`define TCB_MEM_WAIT 2

`endif

//--- src/tcb_bus_pkg.sv
`include "tcb_config.svh"

package tcb_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // enumerations
  ////////////////////////////////////////////////////////////////////////////

  // log2 of transfer size in bytes
  typedef enum logic [1:0] {
    TCB_SIZ_BYTE = 2'd0,
    TCB_SIZ_HALF = 2'd1,
    TCB_SIZ_WORD = 2'd2
  } tcb_siz_t;

  // byte order of the transfer
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  ////////////////////////////////////////////////////////////////////////////
  // data and transfer types
  ////////////////////////////////////////////////////////////////////////////

  // data word, byte lanes or one flat word
  typedef union packed {
    logic [`TCB_BYTES-1:0][7:0] lane;
    logic [8*`TCB_BYTES-1:0]    word;
  } tcb_data_u;

  // log-size request, write data packed from byte 0
  typedef struct packed {
    logic                      wen;
    tcb_ndn_t                  ndn;
    tcb_siz_t                  siz;
    logic [`TCB_ADR_WIDTH-1:0] adr;
    tcb_data_u                 wdt;
  } tcb_req_t;

  // response, status is always ok
  typedef struct packed {
    tcb_data_u rdt;
  } tcb_rsp_t;

endpackage

//--- src/tcb_mem_pkg.sv
`include "tcb_config.svh"

package tcb_mem_pkg;

  // byte-enable request as seen by the memory side
  // wdt already placed on its byte lanes
  typedef struct packed {
    logic                      wen;
    logic [`TCB_BYTES-1:0]     ben;
    logic [`TCB_ADR_WIDTH-1:0] adr;
    tcb_bus_pkg::tcb_data_u    wdt;
  } tcb_ben_req_t;

  // controller sequence
  // idle accepts, wait runs the timer, access strobes the array
  typedef enum logic [1:0] {
    MEM_IDLE    = 2'd0,
    MEM_WAIT    = 2'd1,
    MEM_ACCESS  = 2'd2,
    MEM_RESPOND = 2'd3
  } tcb_mem_state_t;

endpackage

//--- src/tcb_wait_timer.sv
`timescale 1ns/1ps
`include "tcb_config.svh"

module tcb_wait_timer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic done
);

  // wide enough for the load value, also with zero wait states
  localparam int unsigned CNT_W = $clog2(`TCB_MEM_WAIT + 2);

  logic [CNT_W-1:0] cnt;

  // load on start, then count down to zero and stop
  // done is registered on the edge where the count leaves 1
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (start) begin
      cnt  <= CNT_W'(`TCB_MEM_WAIT);
      // zero wait, pulse right on the next cycle
      done <= (`TCB_MEM_WAIT == 0);
    end else begin
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      done <= (cnt == CNT_W'(1));
    end
  end

endmodule

//--- src/tcb_mem_array.sv
`timescale 1ns/1ps
`include "tcb_config.svh"

module tcb_mem_array
  import tcb_bus_pkg::*;
  import tcb_mem_pkg::*;
(
  input  logic         clk,
  input  logic         en,
  input  tcb_ben_req_t req,
  output tcb_data_u    rdt
);

  localparam int unsigned OFF_W = $clog2(`TCB_BYTES);
  localparam int unsigned IDX_W = $clog2(`TCB_MEM_DEPTH);

  // storage, one packed word per entry
  logic [`TCB_BYTES-1:0][7:0] mem [`TCB_MEM_DEPTH];

  logic [IDX_W-1:0] idx;

  // word address, byte offset dropped
  assign idx = req.adr[OFF_W +: IDX_W];

  // write under byte enables
  always_ff @(posedge clk) begin
    if (en && req.wen) begin
      for (int unsigned i = 0; i < `TCB_BYTES; i++) begin
        if (req.ben[i]) begin
          mem[idx][i] <= req.wdt.lane[i];
        end
      end
    end
  end

  // whole word read, repacking happens in the converter
  always_ff @(posedge clk) begin
    if (en && !req.wen) begin
      rdt.lane <= mem[idx];
    end
  end

  // converter always enables at least one lane
  a_wen_has_ben: assert property (@(posedge clk)
    (en && req.wen) |-> (req.ben != '0))
    else $error("write issued with no byte enabled");

endmodule

//--- src/tcb_mem_ctrl.sv
`timescale 1ns/1ps

module tcb_mem_ctrl
  import tcb_mem_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  // request from the converter
  input  tcb_ben_req_t req,
  input  logic         req_vld,
  output logic         req_rdy,
  // response handshake
  output logic         rsp_vld,
  input  logic         rsp_rdy,
  // wait timer
  output logic         tmr_start,
  input  logic         tmr_done,
  // array access
  output logic         mem_en,
  output tcb_ben_req_t mem_req
);

  tcb_mem_state_t state;
  tcb_mem_state_t state_nxt;
  tcb_ben_req_t   req_q;

  // accept only while idle
  assign req_rdy   = (state == MEM_IDLE);
  assign tmr_start = req_vld && req_rdy;

  always_comb begin
    state_nxt = state;
    unique case (state)
      MEM_IDLE:    if (tmr_start) state_nxt = MEM_WAIT;
      MEM_WAIT:    if (tmr_done)  state_nxt = MEM_ACCESS;
      // single access cycle
      MEM_ACCESS:  state_nxt = MEM_RESPOND;
      // hold until the manager takes it
      MEM_RESPOND: if (rsp_rdy)   state_nxt = MEM_IDLE;
      default:     state_nxt = MEM_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MEM_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // request held for the whole transfer
  always_ff @(posedge clk) begin
    if (tmr_start) begin
      req_q <= req;
    end
  end

  assign mem_en  = (state == MEM_ACCESS);
  assign mem_req = req_q;
  assign rsp_vld = (state == MEM_RESPOND);

  // no second request is taken before the response is delivered
  a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
    (req_vld && req_rdy) |=> (!req_rdy until_with (rsp_vld && rsp_rdy)))
    else $error("request accepted while a transfer is in flight");

endmodule

//--- src/tcb_logsize2byteena.sv
`timescale 1ns/1ps
`include "tcb_config.svh"

module tcb_logsize2byteena
  import tcb_bus_pkg::*;
  import tcb_mem_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  // log-size side, manager connects here
  input  tcb_req_t     sub_req,
  input  logic         sub_vld,
  output logic         sub_rdy,
  output tcb_rsp_t     sub_rsp,
  // byte-enable side, memory controller connects here
  output tcb_ben_req_t man_req,
  output logic         man_vld,
  input  logic         man_rdy,
  input  tcb_data_u    man_rdt
);

  // offset bits within a bus word
  localparam int unsigned OFF_W = $clog2(`TCB_BYTES);

  logic [OFF_W-1:0] req_off;
  logic [OFF_W-1:0] rsp_off;
  tcb_siz_t         rsp_siz;
  tcb_ndn_t         rsp_ndn;

  // source lane for byte i, wraps modulo bus width
  // little endian, write subtracts the offset and read adds it
  // big endian mirrors inside the transfer, same on both paths
  function automatic logic [OFF_W-1:0] src_lane(
    input int unsigned      i,
    input logic [OFF_W-1:0] off,
    input tcb_siz_t         siz,
    input tcb_ndn_t         ndn,
    input logic             rd
  );
    logic [OFF_W-1:0] top;
    top = OFF_W'((1 << siz) - 1);
    if (ndn == TCB_BIG) begin
      return top - OFF_W'(i) + off;
    end else if (rd) begin
      return OFF_W'(i) + off;
    end else begin
      return OFF_W'(i) - off;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // request path, no delay
  ////////////////////////////////////////////////////////////////////////////

  assign man_vld = sub_vld;
  assign req_off = sub_req.adr[OFF_W-1:0];

  always_comb begin
    man_req.wen = sub_req.wen;
    man_req.adr = sub_req.adr;
    for (int unsigned i = 0; i < `TCB_BYTES; i++) begin
      // lane enabled when its distance from offset, modulo the bus, fits the size
      man_req.ben[i] = int'(OFF_W'(OFF_W'(i) - req_off)) < (1 << sub_req.siz);
      man_req.wdt.lane[i] = sub_req.wdt.lane[src_lane(i, req_off, sub_req.siz,
                                                      sub_req.ndn, 1'b0)];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response sideband
  ////////////////////////////////////////////////////////////////////////////

  // one transfer in flight, so one register set is enough
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_off <= '0;
      rsp_siz <= TCB_SIZ_BYTE;
      rsp_ndn <= TCB_LITTLE;
    end else if (sub_vld && sub_rdy) begin
      rsp_off <= req_off;
      rsp_siz <= sub_req.siz;
      rsp_ndn <= sub_req.ndn;
    end
  end

  // repack read bytes toward byte 0, lanes past the size read as zero
  always_comb begin
    for (int unsigned i = 0; i < `TCB_BYTES; i++) begin
      if (i < (1 << rsp_siz)) begin
        sub_rsp.rdt.lane[i] = man_rdt.lane[src_lane(i, rsp_off, rsp_siz, rsp_ndn, 1'b1)];
      end else begin
        sub_rsp.rdt.lane[i] = 8'h00;
      end
    end
  end

  // ready comes straight from the controller
  assign sub_rdy = man_rdy;

  // reserved size code would enable more bytes than the bus carries
  a_siz_fits_bus: assert property (@(posedge clk) disable iff (reset)
    (sub_vld && sub_rdy) |-> ((1 << sub_req.siz) <= `TCB_BYTES))
    else $error("accepted request size exceeds bus width");

endmodule

//--- src/tcb_mem_subsys.sv
`timescale 1ns/1ps

module tcb_mem_subsys
  import tcb_bus_pkg::*;
  import tcb_mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // log-size request
  input  tcb_req_t req,
  input  logic     req_vld,
  output logic     req_rdy,
  // response
  output tcb_rsp_t rsp,
  output logic     rsp_vld,
  input  logic     rsp_rdy
);

  ////////////////////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////////////////////

  // converter to controller
  tcb_ben_req_t ben_req;
  logic         ben_vld;
  logic         ben_rdy;

  // controller to timer and array
  logic         tmr_start;
  logic         tmr_done;
  logic         mem_en;
  tcb_ben_req_t mem_req;
  tcb_data_u    mem_rdt;

  // size and endianness handling
  tcb_logsize2byteena u_conv (
    .clk     (clk),
    .reset   (reset),
    .sub_req (req),
    .sub_vld (req_vld),
    .sub_rdy (req_rdy),
    .sub_rsp (rsp),
    .man_req (ben_req),
    .man_vld (ben_vld),
    .man_rdy (ben_rdy),
    .man_rdt (mem_rdt)
  );

  // sequencing
  tcb_mem_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req       (ben_req),
    .req_vld   (ben_vld),
    .req_rdy   (ben_rdy),
    .rsp_vld   (rsp_vld),
    .rsp_rdy   (rsp_rdy),
    .tmr_start (tmr_start),
    .tmr_done  (tmr_done),
    .mem_en    (mem_en),
    .mem_req   (mem_req)
  );

  // wait states
  tcb_wait_timer u_tmr (
    .clk   (clk),
    .reset (reset),
    .start (tmr_start),
    .done  (tmr_done)
  );

  // storage
  tcb_mem_array u_mem (
    .clk (clk),
    .en  (mem_en),
    .req (mem_req),
    .rdt (mem_rdt)
  );

endmodule

//--- tb/tcb_clk_gen.sv
`timescale 1ns/1ps

module tcb_clk_gen #(
  // period in ns
  parameter int unsigned PERIOD = 100
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

//--- tb/tcb_mem_subsys_tb.sv
`timescale 1ns/1ps
`include "tcb_config.svh"

module tcb_mem_subsys_tb
  import tcb_bus_pkg::*;
();

  localparam int unsigned BYTES   = `TCB_BYTES;
  localparam int unsigned WORDS   = `TCB_MEM_DEPTH;
  localparam int unsigned ADR_W   = `TCB_ADR_WIDTH;
  localparam int          MASK    = `TCB_BYTES - 1;
  // accept edge to first rsp_vld edge
  localparam int unsigned LAT     = `TCB_MEM_WAIT + 2;
  localparam int unsigned TIMEOUT = 200;

  logic     clk;
  logic     reset;
  tcb_req_t req;
  logic     req_vld;
  logic     req_rdy;
  tcb_rsp_t rsp;
  logic     rsp_vld;
  logic     rsp_rdy;

  // shadow memory, one entry per byte
  logic [7:0]         shadow [BYTES*WORDS];
  // scoreboard, one entry per issued request
  logic [8*BYTES-1:0] exp_q [$];
  bit                 chk_q [$];
  string              name_q [$];
  string              test_name;
  int unsigned        issued;
  int unsigned        taken;
  int unsigned        cycle;
  int unsigned        accept_cyc;
  logic               pending;
  logic               rsp_vld_q;
  logic               bp_en;

  tcb_clk_gen #(.PERIOD(100)) u_clk (.clk(clk));

  tcb_mem_subsys UUT (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .rsp_rdy (rsp_rdy)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reporting and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Error: %s expected %h actual %h", name, exp, act);
    $display("sim failed");
    $fatal(1);
  endtask

  // repacks a stored word toward byte 0
  function automatic logic [8*BYTES-1:0] expect_rdt(input logic [BYTES-1:0][7:0] mw,
      input int off, input tcb_siz_t siz, input tcb_ndn_t ndn);
    logic [BYTES-1:0][7:0] r;
    int n;
    n = 1 << siz;
    for (int i = 0; i < int'(BYTES); i++) begin
      if (i >= n) begin
        r[i] = 8'h00;
      end else if (ndn == TCB_BIG) begin
        r[i] = mw[(n - 1 - i + off) & MASK];
      end else begin
        r[i] = mw[(i + off) & MASK];
      end
    end
    return r;
  endfunction

  // places write bytes into the shadow, wraps within the word
  task automatic shadow_write(input logic [ADR_W-1:0] adr, input tcb_siz_t siz,
      input tcb_ndn_t ndn, input tcb_data_u wdt);
    int base;
    int n;
    int off;
    int j;
    base = ((adr / BYTES) % WORDS) * BYTES;
    n    = 1 << siz;
    off  = adr % BYTES;
    for (int i = 0; i < int'(BYTES); i++) begin
      // distance from offset decides the enable
      j = (i - off) & MASK;
      if (j < n) begin
        shadow[base + i] = wdt.lane[(ndn == TCB_BIG) ? (n - 1 - j) : j];
      end
    end
  endtask

  // fill value, mixes every address bit
  function automatic logic [31:0] fill_word(input int unsigned w);
    return (32'(w) + 32'd1) * 32'h9e37_79b9;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // called just after a rising edge, returns just after the accept edge
  task automatic issue_req(input logic wen, input tcb_ndn_t ndn, input tcb_siz_t siz,
      input logic [ADR_W-1:0] adr, input logic [31:0] wdt);
    int unsigned           waited;
    int unsigned           base;
    logic [BYTES-1:0][7:0] mw;
    tcb_data_u             d;
    base   = ((adr / BYTES) % WORDS) * BYTES;
    d.word = wdt;
    for (int i = 0; i < int'(BYTES); i++) begin
      mw[i] = shadow[base + i];
    end
    exp_q.push_back(expect_rdt(mw, adr % BYTES, siz, ndn));
    chk_q.push_back(!wen);
    name_q.push_back(test_name);
    if (wen) begin
      shadow_write(adr, siz, ndn, d);
    end
    req.wen  = wen;
    req.ndn  = ndn;
    req.siz  = siz;
    req.adr  = adr;
    req.wdt  = d;
    req_vld  = 1'b1;
    issued++;
    waited = 0;
    @(negedge clk);
    while (!req_rdy) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("timeout waiting for the request to be accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_vld = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (taken != issued) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("timeout waiting for outstanding responses");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checking, sampled mid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) cycle <= cycle + 1;

  always @(negedge clk) begin
    if (!reset) begin
      if (pending) begin
        assert (!req_rdy) else abort_run("req_rdy high while a response is pending");
      end
      // first cycle of a response
      if (rsp_vld && !rsp_vld_q) begin
        assert (pending) else abort_run("response raised with no request in flight");
        assert (cycle - accept_cyc == LAT)
          else value_error({name_q[0], " latency"}, LAT, cycle - accept_cyc);
      end
      if (rsp_vld && rsp_rdy) begin
        assert (exp_q.size() != 0) else abort_run("response taken with nothing expected");
        // write responses carry no data
        if (chk_q[0]) begin
          assert (rsp.rdt.word === exp_q[0])
            else value_error(name_q[0], exp_q[0], rsp.rdt.word);
        end
        void'(exp_q.pop_front());
        void'(chk_q.pop_front());
        void'(name_q.pop_front());
        taken++;
        pending = 1'b0;
      end
      // handshake completes on the coming edge
      if (req_vld && req_rdy) begin
        pending    = 1'b1;
        accept_cyc = cycle + 1;
      end
      rsp_vld_q = rsp_vld;
    end
  end

  // response back-pressure
  always @(posedge clk) begin
    #1;
    if (bp_en) begin
      rsp_rdy = (($urandom % 3) != 0);
    end else begin
      rsp_rdy = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [ADR_W-1:0] a;
    void'($urandom(32'h7276_4eac));
    reset     = 1'b1;
    req       = '0;
    req_vld   = 1'b0;
    rsp_rdy   = 1'b1;
    bp_en     = 1'b0;
    pending   = 1'b0;
    rsp_vld_q = 1'b0;
    issued    = 0;
    taken     = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // known contents everywhere
    test_name = "fill";
    for (int unsigned w = 0; w < WORDS; w++) begin
      issue_req(1'b1, TCB_LITTLE, TCB_SIZ_WORD, ADR_W'(w * BYTES), fill_word(w));
    end

    // 1: aligned word round trip
    test_name = "aligned_word";
    for (int k = 0; k < 8; k++) begin
      a = ADR_W'(($urandom % WORDS) * BYTES);
      issue_req(1'b1, TCB_LITTLE, TCB_SIZ_WORD, a, $urandom);
      issue_req(1'b0, TCB_LITTLE, TCB_SIZ_WORD, a, 32'h0);
    end

    // 2: byte and half lanes merged into one word
    test_name = "byte_half_merge";
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < int'(BYTES); off++) begin
        a = ADR_W'(20 * BYTES + off);
        issue_req(1'b1, TCB_LITTLE, tcb_siz_t'(s), a, $urandom);
        issue_req(1'b0, TCB_LITTLE, TCB_SIZ_WORD, ADR_W'(20 * BYTES), 32'h0);
      end
    end

    // 3: big endian, every size and offset
    test_name = "big_endian";
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < int'(BYTES); off++) begin
        a = ADR_W'(40 * BYTES + off);
        issue_req(1'b1, TCB_BIG, tcb_siz_t'(s), a, $urandom);
        issue_req(1'b0, TCB_BIG, tcb_siz_t'(s), a, 32'h0);
        issue_req(1'b0, TCB_LITTLE, TCB_SIZ_WORD, ADR_W'(40 * BYTES), 32'h0);
      end
    end

    // 4: transfers that wrap past the word end
    test_name = "unaligned_wrap";
    for (int off = 1; off < int'(BYTES); off++) begin
      a = ADR_W'(60 * BYTES + off);
      issue_req(1'b1, TCB_LITTLE, TCB_SIZ_WORD, a, $urandom);
      issue_req(1'b0, TCB_LITTLE, TCB_SIZ_WORD, a, 32'h0);
      issue_req(1'b0, TCB_LITTLE, TCB_SIZ_WORD, ADR_W'(60 * BYTES), 32'h0);
    end
    a = ADR_W'(61 * BYTES + MASK);
    issue_req(1'b1, TCB_LITTLE, TCB_SIZ_HALF, a, $urandom);
    issue_req(1'b0, TCB_LITTLE, TCB_SIZ_HALF, a, 32'h0);
    issue_req(1'b0, TCB_LITTLE, TCB_SIZ_WORD, ADR_W'(61 * BYTES), 32'h0);

    // 5: random traffic under response back-pressure
    test_name = "backpressure";
    bp_en = 1'b1;
    for (int k = 0; k < 40; k++) begin
      a = ADR_W'(($urandom % 8) * BYTES + ($urandom % BYTES));
      issue_req(1'($urandom % 2), tcb_ndn_t'($urandom % 2), tcb_siz_t'($urandom % 3),
                a, $urandom);
    end
    wait_drained();
    bp_en = 1'b0;

    // idle tail, a stray or repeated response still hits the checker
    repeat (LAT + 2) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+src
src/tcb_bus_pkg.sv
src/tcb_mem_pkg.sv
src/tcb_wait_timer.sv
src/tcb_mem_array.sv
src/tcb_mem_ctrl.sv
src/tcb_logsize2byteena.sv
src/tcb_mem_subsys.sv
tb/tcb_clk_gen.sv
tb/tcb_mem_subsys_tb.sv

//--- Makefile
# Verilator simulation of the TCB memory subsystem
# all variables can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tcb_mem_subsys_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "test FAILED, no pass line"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
